// ==== design/adapter_pkg.sv ====
package adapter_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  parameter int unsigned XLEN               = 64;
  parameter int unsigned ADDR_W             = 64;
  parameter int unsigned AXI_ID_W           = 4;
  parameter int unsigned LINE_WORDS_DEFAULT = 4;
  // byte offset bits inside one data word
  parameter int unsigned WORD_OFF_W         = $clog2(XLEN / 8);

  // B and R response codes
  parameter logic [1:0] RESP_OKAY   = 2'b00;
  parameter logic [1:0] RESP_EXOKAY = 2'b01;

  typedef enum logic {
    REQ_SINGLE = 1'b0,
    REQ_LINE   = 1'b1
  } req_kind_e;

  // ------------------------------
  // cache side request
  // ------------------------------
  // excl is LR on a read and SC on a write
  typedef struct packed {
    req_kind_e             kind;
    logic                  we;
    logic [ADDR_W-1:0]     addr;
    logic [1:0]            size;
    logic                  excl;
    logic [AXI_ID_W-1:0]   id;
  } mem_req_t;

  // ------------------------------
  // AXI channels
  // ------------------------------
  // shared by AW and AR, burst type is always INCR
  typedef struct packed {
    logic [ADDR_W-1:0]     addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic                  lock;
    logic [AXI_ID_W-1:0]   id;
  } ax_chan_t;

  typedef struct packed {
    logic [XLEN-1:0]       data;
    logic [XLEN/8-1:0]     strb;
    logic                  last;
  } w_chan_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [1:0]            resp;
  } b_chan_t;

  typedef struct packed {
    logic [XLEN-1:0]       data;
    logic [AXI_ID_W-1:0]   id;
    logic [1:0]            resp;
    logic                  last;
  } r_chan_t;

  // manager outputs
  typedef struct packed {
    ax_chan_t              aw;
    logic                  aw_valid;
    w_chan_t               w;
    logic                  w_valid;
    logic                  b_ready;
    ax_chan_t              ar;
    logic                  ar_valid;
    logic                  r_ready;
  } axi_req_t;

  // subordinate outputs
  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    b_chan_t               b;
    logic                  b_valid;
    logic                  ar_ready;
    r_chan_t               r;
    logic                  r_valid;
  } axi_rsp_t;

  // ------------------------------
  // FSM to collector
  // ------------------------------
  typedef struct packed {
    logic                  valid;
    logic                  sc;
    logic                  exokay;
    logic [1:0]            size;
    logic [AXI_ID_W-1:0]   id;
  } wr_done_t;

  // only the low offset bits are meaningful
  typedef struct packed {
    logic                  valid;
    logic                  line;
    logic [7:0]            offset;
    logic [AXI_ID_W-1:0]   id;
  } rd_start_t;

endpackage

// ==== design/axi_req_decode.sv ====
`timescale 1ns/100ps

module axi_req_decode #(
  parameter int unsigned LINE_WORDS = adapter_pkg::LINE_WORDS_DEFAULT,
  parameter int unsigned IDX_W      = $clog2(LINE_WORDS)
) (
  input  adapter_pkg::mem_req_t mem_req_i,
  output adapter_pkg::ax_chan_t ax_o,
  output logic [IDX_W-1:0]      beats_o,
  output logic [IDX_W-1:0]      offset_o
);

  // bits below the line boundary
  localparam int unsigned LINE_OFF_W = IDX_W + adapter_pkg::WORD_OFF_W;

  logic is_line;
  logic [adapter_pkg::ADDR_W-1:0] line_addr;

  assign is_line   = (mem_req_i.kind == adapter_pkg::REQ_LINE);
  assign line_addr = {mem_req_i.addr[adapter_pkg::ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

  always_comb begin
    ax_o.id = mem_req_i.id;
    if (is_line) begin
      // incrementing burst from the start of the line, full words
      ax_o.addr = line_addr;
      ax_o.len  = 8'(LINE_WORDS - 1);
      ax_o.size = 3'(adapter_pkg::WORD_OFF_W);
      // exclusive bursts are not supported
      ax_o.lock = 1'b0;
      beats_o   = IDX_W'(LINE_WORDS - 1);
      // word that caused the miss
      offset_o  = mem_req_i.addr[LINE_OFF_W-1:adapter_pkg::WORD_OFF_W];
    end else begin
      ax_o.addr = mem_req_i.addr;
      ax_o.len  = 8'd0;
      ax_o.size = {1'b0, mem_req_i.size};
      // LR on AR, SC on AW
      ax_o.lock = mem_req_i.excl;
      beats_o   = '0;
      // single beat is always the critical one
      offset_o  = '0;
    end
  end

endmodule

// ==== design/axi_txn_fsm.sv ====
`timescale 1ns/100ps

module axi_txn_fsm #(
  parameter int unsigned LINE_WORDS = adapter_pkg::LINE_WORDS_DEFAULT,
  parameter int unsigned IDX_W      = $clog2(LINE_WORDS)
) (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             req_i,
  input  adapter_pkg::mem_req_t                            mem_req_i,
  input  logic [LINE_WORDS-1:0][adapter_pkg::XLEN-1:0]     wdata_i,
  input  logic [LINE_WORDS-1:0][adapter_pkg::XLEN/8-1:0]   be_i,
  input  adapter_pkg::ax_chan_t                            ax_i,
  input  logic [IDX_W-1:0]                                 beats_i,
  input  logic [IDX_W-1:0]                                 offset_i,
  input  adapter_pkg::axi_rsp_t                            axi_rsp_i,
  output adapter_pkg::ax_chan_t                            aw_o,
  output adapter_pkg::w_chan_t                             w_o,
  output adapter_pkg::ax_chan_t                            ar_o,
  output logic                                             aw_valid_o,
  output logic                                             w_valid_o,
  output logic                                             ar_valid_o,
  output logic                                             b_ready_o,
  output logic                                             gnt_o,
  output adapter_pkg::rd_start_t                           rd_start_o,
  output adapter_pkg::wr_done_t                            wr_done_o,
  input  logic                                             rd_done_i
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_AW,
    WAIT_LAST_W,
    WAIT_BOTH,
    WAIT_AW_BURST,
    WAIT_B,
    WAIT_RD
  } state_e;

  state_e state_q, state_d;

  // number of W beats already accepted
  logic [IDX_W-1:0] cnt_q, cnt_d;
  logic             sc_q, sc_d;
  logic [1:0]       size_q, size_d;

  logic both_phase;
  logic last_beat;

  // AW and W both still owed, also covers the first cycle of a write
  assign both_phase = (state_q == WAIT_BOTH) ||
                      (state_q == IDLE && req_i && mem_req_i.we);
  assign last_beat  = (cnt_q == beats_i);

  // address channels carry the decoded request as long as it is held
  assign aw_o = ax_i;
  assign ar_o = ax_i;

  // W beat selected by the counter
  assign w_o.data = wdata_i[cnt_q];
  assign w_o.strb = be_i[cnt_q];
  assign w_o.last = last_beat;

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    sc_d       = sc_q;
    size_d     = size_q;

    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    ar_valid_o = 1'b0;
    b_ready_o  = 1'b0;
    gnt_o      = 1'b0;

    rd_start_o        = '0;
    rd_start_o.line   = (mem_req_i.kind == adapter_pkg::REQ_LINE);
    rd_start_o.offset = 8'(offset_i);
    rd_start_o.id     = ax_i.id;

    wr_done_o        = '0;
    wr_done_o.sc     = sc_q;
    wr_done_o.exokay = (axi_rsp_i.b.resp == adapter_pkg::RESP_EXOKAY);
    wr_done_o.size   = size_q;
    wr_done_o.id     = axi_rsp_i.b.id;

    unique case (state_q)
      IDLE: begin
        if (req_i && mem_req_i.we) begin
          // keep what the B response needs
          sc_d   = mem_req_i.excl;
          size_d = mem_req_i.size;
        end else if (req_i) begin
          ar_valid_o = 1'b1;
          if (axi_rsp_i.ar_ready) begin
            gnt_o            = 1'b1;
            rd_start_o.valid = 1'b1;
            state_d          = WAIT_RD;
          end
        end
      end

      WAIT_LAST_W: begin
        w_valid_o = 1'b1;
        if (axi_rsp_i.w_ready) begin
          if (last_beat) begin
            gnt_o   = 1'b1;
            cnt_d   = '0;
            state_d = WAIT_B;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end

      // all W data is out, AW still pending
      WAIT_AW, WAIT_AW_BURST: begin
        aw_valid_o = 1'b1;
        if (axi_rsp_i.aw_ready) begin
          gnt_o   = 1'b1;
          cnt_d   = '0;
          state_d = WAIT_B;
        end
      end

      WAIT_B: begin
        if (axi_rsp_i.b_valid) begin
          b_ready_o       = 1'b1;
          wr_done_o.valid = 1'b1;
          state_d         = IDLE;
        end
      end

      WAIT_RD: begin
        if (rd_done_i) begin
          state_d = IDLE;
        end
      end

      default: ;
    endcase

    // ------------------------------
    // AW and W together
    // ------------------------------
    if (both_phase) begin
      aw_valid_o = 1'b1;
      w_valid_o  = 1'b1;
      unique case ({axi_rsp_i.aw_ready, axi_rsp_i.w_ready})
        2'b11: begin
          if (last_beat) begin
            gnt_o   = 1'b1;
            cnt_d   = '0;
            state_d = WAIT_B;
          end else begin
            cnt_d   = cnt_q + 1'b1;
            state_d = WAIT_LAST_W;
          end
        end
        2'b10: state_d = WAIT_LAST_W;
        2'b01: begin
          if (last_beat) begin
            state_d = (mem_req_i.kind == adapter_pkg::REQ_LINE) ? WAIT_AW_BURST : WAIT_AW;
          end else begin
            cnt_d   = cnt_q + 1'b1;
            state_d = WAIT_BOTH;
          end
        end
        default: state_d = WAIT_BOTH;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      sc_q    <= 1'b0;
      size_q  <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      sc_q    <= sc_d;
      size_q  <= size_d;
    end
  end

endmodule

// ==== design/axi_rsp_collect.sv ====
`timescale 1ns/100ps

module axi_rsp_collect #(
  parameter int unsigned LINE_WORDS = adapter_pkg::LINE_WORDS_DEFAULT,
  parameter int unsigned IDX_W      = $clog2(LINE_WORDS)
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  adapter_pkg::rd_start_t                       rd_start_i,
  input  adapter_pkg::wr_done_t                        wr_done_i,
  input  adapter_pkg::r_chan_t                         r_i,
  input  logic                                         r_valid_i,
  output logic                                         r_ready_o,
  output logic                                         rd_done_o,
  output logic                                         valid_o,
  output logic [LINE_WORDS-1:0][adapter_pkg::XLEN-1:0] rdata_o,
  output logic [adapter_pkg::AXI_ID_W-1:0]             id_o,
  output logic [adapter_pkg::XLEN-1:0]                 critical_word_o,
  output logic                                         critical_word_valid_o
);

  localparam int unsigned XLEN = adapter_pkg::XLEN;

  // read tracking
  logic                  active_q;
  logic                  line_q;
  logic [IDX_W-1:0]      idx_q;
  logic [IDX_W-1:0]      offset_q;
  logic                  done_q;

  // payload
  logic [LINE_WORDS-1:0][XLEN-1:0]     buf_q;
  logic [adapter_pkg::AXI_ID_W-1:0]    id_q;

  logic r_hs;
  logic [XLEN-1:0] sc_word;

  assign r_ready_o = active_q;
  assign r_hs      = r_valid_i & active_q;

  // critical word is forwarded straight from the R channel
  assign critical_word_valid_o = r_hs && (idx_q == offset_q);
  assign critical_word_o       = r_i.data;

  assign rd_done_o = done_q;
  assign valid_o   = done_q | wr_done_i.valid;

  // SC failure for a 32-bit access puts a 1 in both halves
  always_comb begin
    if (wr_done_i.exokay) begin
      sc_word = '0;
    end else if (wr_done_i.size == 2'b10) begin
      sc_word = {32'd1, 32'd1};
    end else begin
      sc_word = XLEN'(1);
    end
  end

  always_comb begin
    rdata_o = '0;
    id_o    = id_q;
    if (wr_done_i.valid) begin
      id_o = wr_done_i.id;
      if (wr_done_i.sc) begin
        rdata_o[0] = sc_word;
      end
    end else if (line_q) begin
      rdata_o = buf_q;
    end else begin
      rdata_o[0] = buf_q[0];
    end
  end

  // ------------------------------
  // read state
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      line_q   <= 1'b0;
      idx_q    <= '0;
      offset_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= r_hs & r_i.last;
      if (rd_start_i.valid) begin
        active_q <= 1'b1;
        line_q   <= rd_start_i.line;
        idx_q    <= '0;
        offset_q <= rd_start_i.offset[IDX_W-1:0];
      end else if (r_hs) begin
        idx_q <= idx_q + 1'b1;
        if (r_i.last) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  // each beat lands in its own slot
  always_ff @(posedge clk_i) begin
    if (r_hs) begin
      buf_q[idx_q] <= r_i.data;
      if (r_i.last) begin
        id_q <= r_i.id;
      end
    end
  end

endmodule

// ==== design/axi_line_adapter.sv ====
`timescale 1ns/100ps

module axi_line_adapter #(
  parameter int unsigned LINE_WORDS = adapter_pkg::LINE_WORDS_DEFAULT
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           req_i,
  input  adapter_pkg::mem_req_t                          mem_req_i,
  input  logic [LINE_WORDS-1:0][adapter_pkg::XLEN-1:0]   wdata_i,
  input  logic [LINE_WORDS-1:0][adapter_pkg::XLEN/8-1:0] be_i,
  output logic                                           gnt_o,
  output logic                                           valid_o,
  output logic [LINE_WORDS-1:0][adapter_pkg::XLEN-1:0]   rdata_o,
  output logic [adapter_pkg::AXI_ID_W-1:0]               id_o,
  output logic [adapter_pkg::XLEN-1:0]                   critical_word_o,
  output logic                                           critical_word_valid_o,
  output adapter_pkg::axi_req_t                          axi_req_o,
  input  adapter_pkg::axi_rsp_t                          axi_rsp_i
);

  localparam int unsigned IDX_W = $clog2(LINE_WORDS);

  adapter_pkg::ax_chan_t  ax;
  logic [IDX_W-1:0]       beats;
  logic [IDX_W-1:0]       offset;
  adapter_pkg::rd_start_t rd_start;
  adapter_pkg::wr_done_t  wr_done;
  logic                   rd_done;

  // ------------------------------
  // request decode
  // ------------------------------
  axi_req_decode #(
    .LINE_WORDS (LINE_WORDS),
    .IDX_W      (IDX_W)
  ) i_decode (
    .mem_req_i (mem_req_i),
    .ax_o      (ax),
    .beats_o   (beats),
    .offset_o  (offset)
  );

  // ------------------------------
  // AXI handshakes
  // ------------------------------
  axi_txn_fsm #(
    .LINE_WORDS (LINE_WORDS),
    .IDX_W      (IDX_W)
  ) i_fsm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .mem_req_i  (mem_req_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .ax_i       (ax),
    .beats_i    (beats),
    .offset_i   (offset),
    .axi_rsp_i  (axi_rsp_i),
    .aw_o       (axi_req_o.aw),
    .w_o        (axi_req_o.w),
    .ar_o       (axi_req_o.ar),
    .aw_valid_o (axi_req_o.aw_valid),
    .w_valid_o  (axi_req_o.w_valid),
    .ar_valid_o (axi_req_o.ar_valid),
    .b_ready_o  (axi_req_o.b_ready),
    .gnt_o      (gnt_o),
    .rd_start_o (rd_start),
    .wr_done_o  (wr_done),
    .rd_done_i  (rd_done)
  );

  // ------------------------------
  // responses
  // ------------------------------
  axi_rsp_collect #(
    .LINE_WORDS (LINE_WORDS),
    .IDX_W      (IDX_W)
  ) i_collect (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .rd_start_i            (rd_start),
    .wr_done_i             (wr_done),
    .r_i                   (axi_rsp_i.r),
    .r_valid_i             (axi_rsp_i.r_valid),
    .r_ready_o             (axi_req_o.r_ready),
    .rd_done_o             (rd_done),
    .valid_o               (valid_o),
    .rdata_o               (rdata_o),
    .id_o                  (id_o),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o)
  );

endmodule

// ==== verif/tb_axi_mem.sv ====
`timescale 1ns/100ps

module tb_axi_mem #(
  parameter int unsigned WORDS = 256
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [31:0]           rnd_i,
  input  adapter_pkg::axi_req_t axi_req_i,
  output adapter_pkg::axi_rsp_t axi_rsp_o
);

  localparam int unsigned IDX_W = $clog2(WORDS);

  logic [63:0] mem [WORDS];
  adapter_pkg::axi_rsp_t rsp_q = '0;
  adapter_pkg::ax_chan_t aw_q, ar_q, aw_s, ar_s;
  adapter_pkg::w_chan_t  w_s;
  logic aw_have, ar_have, w_done;
  logic aw_hs, w_hs, ar_hs, b_hs, r_hs, in_reset;
  logic [7:0] beat;
  logic [63:0] w_data[$];
  logic [7:0]  w_strb[$];
  // single reservation slot
  logic        res_valid;
  logic [63:0] res_addr;
  logic        ok;
  logic [IDX_W-1:0] base;

  assign axi_rsp_o = rsp_q;

  function automatic logic [IDX_W-1:0] word_idx(logic [63:0] addr);
    return addr[IDX_W+2:3];
  endfunction

  // every bit of the word index shows up in the pattern
  function automatic logic [63:0] fill_word(int unsigned i);
    return {16'hfeed, 16'(i), 32'(i) * 32'h9e37_79b1};
  endfunction

  always @(posedge clk_i) begin
    // handshakes and channel contents as seen at the edge
    in_reset = !rst_ni;
    aw_hs    = axi_req_i.aw_valid && rsp_q.aw_ready;
    w_hs     = axi_req_i.w_valid && rsp_q.w_ready;
    ar_hs    = axi_req_i.ar_valid && rsp_q.ar_ready;
    b_hs     = rsp_q.b_valid && axi_req_i.b_ready;
    r_hs     = rsp_q.r_valid && axi_req_i.r_ready;
    aw_s     = axi_req_i.aw;
    w_s      = axi_req_i.w;
    ar_s     = axi_req_i.ar;
    #2;
    if (in_reset) begin
      rsp_q     = '0;
      aw_have   = 1'b0;
      ar_have   = 1'b0;
      w_done    = 1'b0;
      beat      = '0;
      res_valid = 1'b0;
      w_data.delete();
      w_strb.delete();
      for (int i = 0; i < WORDS; i++) begin
        mem[i] = fill_word(i);
      end
    end else begin
      // ------------------------------
      // write side
      // ------------------------------
      if (b_hs) begin
        rsp_q.b_valid = 1'b0;
      end
      if (aw_hs) begin
        aw_q    = aw_s;
        aw_have = 1'b1;
      end
      if (w_hs) begin
        w_data.push_back(w_s.data);
        w_strb.push_back(w_s.strb);
        if (w_s.last) begin
          w_done = 1'b1;
        end
      end
      // commit once the address and all data beats are in
      if (aw_have && w_done && !rsp_q.b_valid && rnd_i[25]) begin
        ok = !aw_q.lock || (res_valid && res_addr == aw_q.addr);
        if (ok) begin
          base = word_idx(aw_q.addr);
          foreach (w_data[i]) begin
            for (int b = 0; b < 8; b++) begin
              if (w_strb[i][b]) begin
                mem[IDX_W'(base + i)][8*b +: 8] = w_data[i][8*b +: 8];
              end
            end
          end
        end
        if (aw_q.lock) begin
          res_valid = 1'b0;
        end
        rsp_q.b.id    = aw_q.id;
        rsp_q.b.resp  = (aw_q.lock && ok) ? adapter_pkg::RESP_EXOKAY : adapter_pkg::RESP_OKAY;
        rsp_q.b_valid = 1'b1;
        aw_have       = 1'b0;
        w_done        = 1'b0;
        w_data.delete();
        w_strb.delete();
      end

      // ------------------------------
      // read side
      // ------------------------------
      if (r_hs) begin
        rsp_q.r_valid = 1'b0;
        if (rsp_q.r.last) begin
          ar_have = 1'b0;
        end else begin
          beat = beat + 8'd1;
        end
      end
      if (ar_hs) begin
        ar_q    = ar_s;
        ar_have = 1'b1;
        beat    = '0;
        // an LR replaces any older reservation
        if (ar_s.lock) begin
          res_valid = 1'b1;
          res_addr  = ar_s.addr;
        end
      end
      if (ar_have && !rsp_q.r_valid && |rnd_i[23:22]) begin
        rsp_q.r_valid = 1'b1;
        rsp_q.r.data  = mem[IDX_W'(word_idx(ar_q.addr) + beat)];
        rsp_q.r.id    = ar_q.id;
        rsp_q.r.resp  = ar_q.lock ? adapter_pkg::RESP_EXOKAY : adapter_pkg::RESP_OKAY;
        rsp_q.r.last  = (beat == ar_q.len);
      end

      // random ready, held low while that channel's transaction is still open
      rsp_q.aw_ready = !aw_have && |rnd_i[17:16];
      rsp_q.w_ready  = !w_done && |rnd_i[19:18];
      rsp_q.ar_ready = !ar_have && |rnd_i[21:20];
    end
  end

endmodule

// ==== verif/tb_axi_line_adapter.sv ====
`timescale 1ns/100ps

module tb_axi_line_adapter;

  localparam int unsigned LW      = 4;
  localparam int unsigned XLEN    = adapter_pkg::XLEN;
  localparam int          TIMEOUT = 400;

  typedef logic [LW-1:0][XLEN-1:0] line_t;

  logic                             clk;
  logic                             rst_n;
  logic                             req;
  adapter_pkg::mem_req_t            mem_req;
  line_t                            wdata;
  logic [LW-1:0][XLEN/8-1:0]        be;
  logic                             gnt;
  logic                             valid;
  line_t                            rdata;
  logic [adapter_pkg::AXI_ID_W-1:0] id;
  logic [XLEN-1:0]                  crit_word;
  logic                             crit_valid;
  adapter_pkg::axi_req_t            axi_req;
  adapter_pkg::axi_rsp_t            axi_rsp;
  logic [31:0]                      rnd = 32'd91;
  logic [7:0]                       ctrl_bits;

  // expectations for the request in flight
  string                 test_name;
  adapter_pkg::ax_chan_t exp_ax;
  line_t                 exp_rdata;
  logic [XLEN-1:0]       exp_crit;
  int                    exp_crit_cnt;
  int                    crit_base;
  int                    w_base;
  int                    crit_total = 0;
  int                    w_total = 0;
  int                    errors = 0;
  int                    timeouts = 0;

  axi_line_adapter #(
    .LINE_WORDS (LW)
  ) DUT (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .req_i                 (req),
    .mem_req_i             (mem_req),
    .wdata_i               (wdata),
    .be_i                  (be),
    .gnt_o                 (gnt),
    .valid_o               (valid),
    .rdata_o               (rdata),
    .id_o                  (id),
    .critical_word_o       (crit_word),
    .critical_word_valid_o (crit_valid),
    .axi_req_o             (axi_req),
    .axi_rsp_i             (axi_rsp)
  );

  tb_axi_mem i_mem (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .rnd_i     (rnd),
    .axi_req_i (axi_req),
    .axi_rsp_o (axi_rsp)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ready and valid delays in the memory model
  always @(negedge clk) rnd <= lcg_next(rnd);

  always @(posedge clk) begin
    if (crit_valid) crit_total <= crit_total + 1;
    if (axi_req.w_valid && axi_rsp.w_ready) w_total <= w_total + 1;
  end

  assign ctrl_bits = {axi_req.aw_valid, axi_req.w_valid, axi_req.ar_valid, axi_req.b_ready,
                      axi_req.r_ready, gnt, valid, crit_valid};

  // ------------------------------
  // checks
  // ------------------------------
  assert property (@(posedge clk) !rst_n |-> ctrl_bits == 8'h00)
    else begin
      errors++;
      $display("error %s ctrl: expected %h actual %h", test_name, 8'h00, $sampled(ctrl_bits));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    axi_req.aw_valid && !axi_rsp.aw_ready |=> axi_req.aw_valid && $stable(axi_req.aw))
    else begin
      errors++;
      $display("%s: AW valid dropped or AW changed before ready", test_name);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    axi_req.w_valid && !axi_rsp.w_ready |=> axi_req.w_valid && $stable(axi_req.w))
    else begin
      errors++;
      $display("%s: W valid dropped or W changed before ready", test_name);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    axi_req.ar_valid && !axi_rsp.ar_ready |=> axi_req.ar_valid && $stable(axi_req.ar))
    else begin
      errors++;
      $display("%s: AR valid dropped or AR changed before ready", test_name);
    end

  assert property (@(posedge clk) disable iff (!rst_n) axi_req.b_ready |-> axi_rsp.b_valid)
    else begin
      errors++;
      $display("%s: B ready raised without B valid", test_name);
    end

  // one grant per request and the request goes away after it
  assert property (@(posedge clk) disable iff (!rst_n) gnt |-> req ##1 !gnt)
    else begin
      errors++;
      $display("%s: grant without request or longer than one cycle", test_name);
    end

  assert property (@(posedge clk) disable iff (!rst_n) axi_req.aw_valid |-> axi_req.aw == exp_ax)
    else begin
      errors++;
      $display("error %s aw: expected %h actual %h", test_name, exp_ax, $sampled(axi_req.aw));
    end

  assert property (@(posedge clk) disable iff (!rst_n) axi_req.ar_valid |-> axi_req.ar == exp_ax)
    else begin
      errors++;
      $display("error %s ar: expected %h actual %h", test_name, exp_ax, $sampled(axi_req.ar));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    axi_req.w_valid |-> axi_req.w.last == ((w_total - w_base) == exp_ax.len))
    else begin
      errors++;
      $display("error %s wlast: expected %b actual %b", test_name,
               ($sampled(w_total) - $sampled(w_base)) == exp_ax.len, $sampled(axi_req.w.last));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> rdata == exp_rdata && id == exp_ax.id)
    else begin
      errors++;
      $display("error %s rsp: expected %h/%h actual %h/%h", test_name, exp_rdata, exp_ax.id,
               $sampled(rdata), $sampled(id));
    end

  assert property (@(posedge clk) disable iff (!rst_n) crit_valid |-> crit_word == exp_crit)
    else begin
      errors++;
      $display("error %s crit: expected %h actual %h", test_name, exp_crit, $sampled(crit_word));
    end

  assert property (@(posedge clk) disable iff (!rst_n)
    valid |-> crit_total - crit_base == exp_crit_cnt)
    else begin
      errors++;
      $display("error %s crit count: expected %0d actual %0d", test_name, exp_crit_cnt,
               $sampled(crit_total) - $sampled(crit_base));
    end

  // read response one cycle after the last R beat
  assert property (@(posedge clk) disable iff (!rst_n)
    axi_rsp.r_valid && axi_req.r_ready && axi_rsp.r.last |=> valid)
    else begin
      errors++;
      $display("%s: no response one cycle after the last R beat", test_name);
    end

  // write response in the B handshake cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    axi_rsp.b_valid && axi_req.b_ready |-> valid)
    else begin
      errors++;
      $display("%s: no response in the B handshake cycle", test_name);
    end

  // ------------------------------
  // stimulus
  // ------------------------------
  function automatic line_t word_line(logic [XLEN-1:0] w);
    line_t l;
    l    = '0;
    l[0] = w;
    return l;
  endfunction

  function automatic logic [63:0] merge_bytes(logic [63:0] old_w, logic [63:0] new_w,
                                              logic [7:0] strb);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // starts and ends 2 ns after a rising edge
  task automatic transfer(input string name, input adapter_pkg::req_kind_e kind, input logic we,
                          input logic [63:0] addr, input logic [1:0] size, input logic excl,
                          input logic [3:0] rid, input line_t data,
                          input logic [LW-1:0][7:0] strb, input line_t exp_data,
                          input logic [63:0] exp_cw);
    int n;
    test_name = name;
    exp_ax.id = rid;
    if (kind == adapter_pkg::REQ_LINE) begin
      exp_ax.addr = {addr[63:5], 5'b0};
      exp_ax.len  = 8'(LW - 1);
      exp_ax.size = 3'd3;
      exp_ax.lock = 1'b0;
    end else begin
      exp_ax.addr = addr;
      exp_ax.len  = 8'd0;
      exp_ax.size = {1'b0, size};
      exp_ax.lock = excl;
    end
    exp_rdata    = exp_data;
    exp_crit     = exp_cw;
    exp_crit_cnt = we ? 0 : 1;
    crit_base    = crit_total;
    w_base       = w_total;
    mem_req      = '{kind: kind, we: we, addr: addr, size: size, excl: excl, id: rid};
    wdata        = data;
    be           = strb;
    req          = 1'b1;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (gnt) break;
    end
    if (n == TIMEOUT) begin
      timeouts++;
      $display("timeout: no grant for %s", name);
    end
    @(posedge clk);
    #2 req = 1'b0;
    for (n = 0; n < TIMEOUT; n++) begin
      @(negedge clk);
      if (valid) break;
    end
    if (n == TIMEOUT) begin
      timeouts++;
      $display("timeout: no response for %s", name);
    end
    @(posedge clk);
    #2;
  endtask

  initial begin
    int          i;
    logic [31:0] s;
    logic [63:0] a;
    logic [63:0] w;
    logic [63:0] w2;
    line_t       ln;
    req       = 1'b0;
    mem_req   = '0;
    wdata     = '0;
    be        = '0;
    exp_ax    = '0;
    exp_rdata = '0;
    exp_crit  = '0;
    test_name = "reset";
    rst_n     = 1'b1;
    #1 rst_n  = 1'b0;
    repeat (4) @(posedge clk);
    #2 rst_n = 1'b1;

    s = rnd;
    for (i = 0; i < LW; i++) begin
      s     = lcg_next(s);
      ln[i] = {s, lcg_next(s)};
    end
    w  = {lcg_next(s), rnd};
    w2 = {rnd, lcg_next(s)};

    // line write and a line read from inside the line
    transfer("line_write", adapter_pkg::REQ_LINE, 1'b1, 64'h100, 2'd3, 1'b0, 4'h1, ln, '1,
             '0, '0);
    transfer("line_read", adapter_pkg::REQ_LINE, 1'b0, 64'h113, 2'd3, 1'b0, 4'h2, '0, '0,
             ln, ln[2]);

    // partial single write then read back
    transfer("single_write", adapter_pkg::REQ_SINGLE, 1'b1, 64'h108, 2'd2, 1'b0, 4'h3,
             word_line(w), 32'h0000_000f, '0, '0);
    a = merge_bytes(ln[1], w, 8'h0f);
    transfer("single_read", adapter_pkg::REQ_SINGLE, 1'b0, 64'h108, 2'd3, 1'b0, 4'h4, '0, '0,
             word_line(a), a);

    // exclusive pair followed by store-conditionals without a reservation
    transfer("lr", adapter_pkg::REQ_SINGLE, 1'b0, 64'h110, 2'd3, 1'b1, 4'h5, '0, '0,
             word_line(ln[2]), ln[2]);
    transfer("sc_pass", adapter_pkg::REQ_SINGLE, 1'b1, 64'h110, 2'd3, 1'b1, 4'h6,
             word_line(w2), 32'h0000_00ff, '0, '0);
    transfer("sc_fail_w", adapter_pkg::REQ_SINGLE, 1'b1, 64'h110, 2'd2, 1'b1, 4'h7,
             word_line(w), 32'h0000_000f, word_line(64'h0000_0001_0000_0001), '0);
    transfer("sc_fail_d", adapter_pkg::REQ_SINGLE, 1'b1, 64'h110, 2'd3, 1'b1, 4'h8,
             word_line(w), 32'h0000_00ff, word_line(64'd1), '0);
    transfer("sc_readback", adapter_pkg::REQ_SINGLE, 1'b0, 64'h110, 2'd3, 1'b0, 4'h9, '0, '0,
             word_line(w2), w2);

    // random words under random stalls
    for (i = 0; i < 4; i++) begin
      a = 64'h200 + {rnd[29:24], 3'b000};
      w = {rnd, lcg_next(rnd)};
      transfer("random_write", adapter_pkg::REQ_SINGLE, 1'b1, a, 2'd3, 1'b0, 4'(10 + i),
               word_line(w), 32'h0000_00ff, '0, '0);
      transfer("random_read", adapter_pkg::REQ_SINGLE, 1'b0, a, 2'd3, 1'b0, 4'(i), '0, '0,
               word_line(w), w);
    end

    repeat (3) @(posedge clk);
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
design/adapter_pkg.sv
design/axi_req_decode.sv
design/axi_txn_fsm.sv
design/axi_rsp_collect.sv
design/axi_line_adapter.sv
verif/tb_axi_mem.sv
verif/tb_axi_line_adapter.sv

// ==== Bender.yml ====
package:
  name: axi_line_adapter

sources:
  - design/adapter_pkg.sv
  - design/axi_req_decode.sv
  - design/axi_txn_fsm.sv
  - design/axi_rsp_collect.sv
  - design/axi_line_adapter.sv
  - target: test
    files:
      - verif/tb_axi_mem.sv
      - verif/tb_axi_line_adapter.sv
